// File: leaf_top.f
+incdir+.
leaf_pkg.sv
leaf_packet_rx.sv
leaf_user_kernel.sv
leaf_packet_tx.sv
leaf_top.sv
leaf_checker.sv
tb_leaf_top.sv

// File: Makefile
# Verilator build and run for the leaf testbench.

VERILATOR ?= verilator
TOP       ?= tb_leaf_top
FILELIST  ?= leaf_top.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps
RUN_FLAGS ?= +verilator+error+limit+100
PASS_MSG  ?= Regression passed

SOURCES := $(wildcard *.sv *.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# the log decides the result, so a crashed run also fails.
run: compile
	-./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "^$(PASS_MSG)$$" $(LOG) || (echo "pass message not found in $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: tb_leaf_top.sv
`include "leaf_params.svh"

`default_nettype none

module tb_leaf_top
    import leaf_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int NUM_IN = `LEAF_NUM_IN_PORTS;
    localparam int DEPTH = `LEAF_QUEUE_DEPTH;
    localparam int CAPACITY = DEPTH + 2;   // queue, kernel output register, holding register.
    localparam int WAIT_LIMIT = 2000;
    localparam int NUM_RANDOM = 600;

    logic         clk;
    logic         rst_n;
    leaf_packet_t pkt_in;
    leaf_packet_t pkt_out;
    logic         resend;
    logic [15:0]  drop_count;

    // reference model state.
    logic [31:0] exp_q [NUM_OUT][$];
    logic [31:0] pend_a [$];
    logic [31:0] pend_b [$];
    route_t      exp_route [NUM_OUT];
    logic [31:0] run_sum;
    int          sent [NUM_IN];
    int          seen [NUM_OUT];
    int          exp_drops;
    int          errors;
    int          checked;
    int          burst_left;
    bit          random_bursts;
    bit          hold_resend;
    bit          timed_out;

    leaf_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pkt_in     (pkt_in),
        .pkt_out    (pkt_out),
        .resend     (resend),
        .drop_count (drop_count)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // ------------------------------------------------------------
    // output monitor
    // ------------------------------------------------------------
    task automatic check_output();
        data_body_t  body;
        int          port;
        logic [31:0] want;
        body = pkt_out.body.data;
        port = -1;
        if (resend) begin
            assert (pkt_out == '0) else begin
                errors++;
                $display("Error at %0t: pkt_out is %h while resend is high", $time, pkt_out);
            end
        end else if (pkt_out.vld) begin
            for (int p = 0; p < NUM_OUT; p++) begin
                if (exp_route[p].dst_port == body.dst_port) port = p;
            end
            assert (port >= 0) else begin
                errors++;
                $display("Error at %0t: packet with unknown dst_port %0d", $time, body.dst_port);
            end
            if (port >= 0) begin
                assert (body.dst_leaf == exp_route[port].dst_leaf) else begin
                    errors++;
                    $display("Error at %0t: port %0d dst_leaf %0d, expected %0d", $time,
                             port + 1, body.dst_leaf, exp_route[port].dst_leaf);
                end
                assert (body.spare == '0) else begin
                    errors++;
                    $display("Error at %0t: spare field is %h", $time, body.spare);
                end
                assert (exp_q[port].size() > 0) else begin
                    errors++;
                    $display("Error at %0t: unexpected packet for port %0d", $time, port + 1);
                end
                if (exp_q[port].size() > 0) begin
                    want = exp_q[port].pop_front();
                    assert (body.payload == want) else begin
                        errors++;
                        $display("Error at %0t: port %0d payload %h, expected %h", $time,
                                 port + 1, body.payload, want);
                    end
                    seen[port]++;
                    checked++;
                end
            end
        end
    endtask

    // one clock cycle drives on the rising edge and looks at the outputs mid-cycle.
    task automatic step(input leaf_packet_t pkt);
        @(posedge clk);
        if (random_bursts && burst_left == 0 && $urandom_range(0, 15) == 0) begin
            burst_left = int'($urandom_range(1, 6));
        end
        pkt_in <= pkt;
        resend <= hold_resend || (burst_left != 0);
        if (burst_left != 0) burst_left--;
        @(negedge clk);
        check_output();
    endtask

    function automatic int outstanding(input int port);
        return sent[port - 1] - seen[port - 1];
    endfunction

    function automatic bit busy();
        bit any;
        any = 1'b0;
        for (int p = 0; p < NUM_OUT; p++) begin
            if (exp_q[p].size() != 0) any = 1'b1;
        end
        return any;
    endfunction

    // ------------------------------------------------------------
    // stimulus
    // ------------------------------------------------------------
    task automatic send_data(input int port, input logic [31:0] value, input bit accepted);
        leaf_packet_t pkt;
        logic [31:0]  a;
        logic [31:0]  b;
        pkt = '0;
        pkt.vld = 1'b1;
        pkt.body.data.dst_leaf = 5'($urandom());
        pkt.body.data.dst_port = 4'(port);
        pkt.body.data.payload = value;
        step(pkt);
        if (!accepted) begin
            exp_drops++;
        end else begin
            sent[port - 1]++;
            if (port == 1) begin
                pend_a.push_back(value);
            end else if (port == 2) begin
                pend_b.push_back(value);
            end else begin
                run_sum = run_sum + value;   // wraps at 32 bits.
                exp_q[2].push_back(value);
                exp_q[3].push_back(run_sum);
            end
            if (pend_a.size() > 0 && pend_b.size() > 0) begin
                a = pend_a.pop_front();
                b = pend_b.pop_front();
                exp_q[0].push_back(a + b);
                exp_q[1].push_back(a - b);
            end
        end
    endtask

    task automatic send_bad();
        leaf_packet_t pkt;
        pkt = '0;
        pkt.vld = 1'b1;
        pkt.body.data.dst_port = 4'($urandom_range(4, 15));
        pkt.body.data.payload = $urandom();
        step(pkt);
        exp_drops++;
    endtask

    // distinct dst_port values let a packet name its own output port.
    task automatic configure_routes();
        leaf_packet_t pkt;
        logic [3:0]   perm [NUM_OUT];
        logic [3:0]   tmp;
        int           j;
        for (int p = 0; p < NUM_OUT; p++) perm[p] = 4'(p + 1);
        for (int p = NUM_OUT - 1; p > 0; p--) begin
            j = int'($urandom_range(0, p));
            tmp = perm[p];
            perm[p] = perm[j];
            perm[j] = tmp;
        end
        for (int p = 0; p < NUM_OUT; p++) begin
            exp_route[p].dst_leaf = 5'($urandom());
            exp_route[p].dst_port = perm[p];
            pkt = '0;
            pkt.vld = 1'b1;
            pkt.body.cfg.cfg_out_port = 4'(p + 1);
            pkt.body.cfg.cfg_dst_leaf = exp_route[p].dst_leaf;
            pkt.body.cfg.cfg_dst_port = exp_route[p].dst_port;
            step(pkt);
        end
    endtask

    task automatic wait_room(input int port);
        int waited;
        waited = 0;
        while (!timed_out && outstanding(port) >= DEPTH) begin
            step('0);
            waited++;
            if (waited >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout at %0t: input port %0d never made room", $time, port);
            end
        end
    endtask

    task automatic random_phase(input int count);
        int kind;
        int port;
        random_bursts = 1'b1;
        for (int n = 0; n < count && !timed_out; n++) begin
            kind = int'($urandom_range(0, 19));
            port = 1 + (kind % 3);
            // in 1 and in 2 only drain as pairs, so keep them close.
            if (port == 1 && sent[0] - sent[1] >= 4) port = 2;
            else if (port == 2 && sent[1] - sent[0] >= 4) port = 1;
            if (kind < 4) begin
                step('0);
            end else if (kind == 4) begin
                send_bad();
            end else begin
                wait_room(port);
                if (!timed_out) send_data(port, $urandom(), 1'b1);
            end
        end
        random_bursts = 1'b0;
    endtask

    task automatic balance_pairs();
        int port;
        while (!timed_out && sent[0] != sent[1]) begin
            port = (sent[0] < sent[1]) ? 1 : 2;
            wait_room(port);
            if (!timed_out) send_data(port, $urandom(), 1'b1);
        end
    endtask

    task automatic drain(input string phase);
        int waited;
        int quiet;
        waited = 0;
        quiet = 0;
        while (!timed_out && (busy() || quiet < 4)) begin
            step('0);
            waited++;
            quiet = busy() ? 0 : quiet + 1;
            if (waited >= WAIT_LIMIT) begin
                timed_out = 1'b1;
                $display("Timeout at %0t: results of %s never drained", $time, phase);
            end
        end
    endtask

    // with resend held the kernel stalls after two words and the rest fill queue 3.
    task automatic overrun_burst();
        hold_resend = 1'b1;
        step('0);
        step('0);
        for (int n = 0; n < CAPACITY + 4; n++) begin
            send_data(3, $urandom(), n < CAPACITY);
        end
        for (int n = 0; n < 3; n++) send_bad();
        for (int n = 0; n < 4; n++) step('0);
        hold_resend = 1'b0;
    endtask

    task automatic check_drops(input string phase);
        if (!timed_out) begin
            assert (drop_count == 16'(exp_drops)) else begin
                errors++;
                $display("Error at %0t: drop_count %0d after %s, expected %0d", $time,
                         drop_count, phase, exp_drops);
            end
        end
    endtask

    // ------------------------------------------------------------
    // main sequence
    // ------------------------------------------------------------
    initial begin
        int assert_fails;
        void'($urandom(81797));
        rst_n = 1'b0;
        pkt_in = '0;
        resend = 1'b0;
        run_sum = '0;
        exp_drops = 0;
        errors = 0;
        checked = 0;
        burst_left = 0;
        random_bursts = 1'b0;
        hold_resend = 1'b0;
        timed_out = 1'b0;
        for (int p = 0; p < NUM_OUT; p++) begin
            exp_route[p] = '0;
            seen[p] = 0;
        end
        for (int p = 0; p < NUM_IN; p++) sent[p] = 0;

        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (drop_count == '0 && pkt_out == '0) else begin
            errors++;
            $display("Error at %0t: outputs not cleared by reset", $time);
        end

        configure_routes();
        random_phase(NUM_RANDOM);
        balance_pairs();
        drain("random traffic");
        check_drops("random traffic");
        if (!timed_out) overrun_burst();
        drain("queue overrun");
        check_drops("queue overrun");

        assert_fails = dut0.packet_tx0.tx_checker0.fail_count +
                       dut0.user_kernel0.kernel_checker0.fail_count;
        $display("Summary: %0d errors, %0d assertion failures, %0d packets checked, %0d timeouts",
                 errors, assert_fails, checked, int'(timed_out));
        if (errors == 0 && assert_fails == 0 && !timed_out) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: leaf_checker.sv
`include "leaf_params.svh"

`default_nettype none

module leaf_checker
    import leaf_pkg::*;
#(
    parameter int N = 4,
    parameter bit HAS_PKT = 1'b1
) (
    input logic            clk,
    input logic            rst_n,
    input stream_t [N-1:0] strm,
    input logic [N-1:0]    ack,
    input logic            resend,
    input leaf_packet_t    pkt
);

    timeunit 1ns;
    timeprecision 1ps;

    logic [N-1:0]    vld;
    logic [N-1:0]    wait_q;   // offered last cycle and not taken.
    logic [N-1:0]    held_ok;
    stream_t [N-1:0] strm_q;
    int              hold_fails = 0;
    int              blank_fails = 0;
    int              reset_fails = 0;
    int              fail_count;

    assign fail_count = hold_fails + blank_fails + reset_fails;

    always_comb begin
        for (int i = 0; i < N; i++) begin
            vld[i] = strm[i].vld;
            held_ok[i] = !wait_q[i] || (strm[i].vld && (strm[i].data == strm_q[i].data));
        end
    end

    always_ff @(posedge clk) begin
        wait_q <= vld & ~ack;
        strm_q <= strm;
    end

    assert property (@(posedge clk) disable iff (!rst_n) &held_ok)
        else begin
            hold_fails++;
            $error("stream word changed or vanished before its ack");
        end

    if (HAS_PKT) begin : g_pkt
        assert property (@(posedge clk) disable iff (!rst_n) resend |-> (pkt == '0))
            else begin
                blank_fails++;
                $error("pkt_out not blank while resend is high");
            end
    end

    assert property (@(posedge clk) !rst_n |=> (vld == '0) && !pkt.vld)
        else begin
            reset_fails++;
            $error("valid output high right after reset");
        end

endmodule

bind leaf_packet_tx leaf_checker #(.N(`LEAF_NUM_OUT_PORTS)) tx_checker0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .strm   (out_stream),
    .ack    (out_ack),
    .resend (resend),
    .pkt    (pkt_out)
);

// the kernel side has no tree output, so only the stream checks apply.
bind leaf_user_kernel leaf_checker #(.N(`LEAF_NUM_IN_PORTS), .HAS_PKT(1'b0)) kernel_checker0 (
    .clk    (clk),
    .rst_n  (rst_n),
    .strm   (in_stream),
    .ack    (in_ack),
    .resend (1'b0),
    .pkt    ('0)
);

`default_nettype wire

// File: leaf_top.sv
`include "leaf_params.svh"

`default_nettype none

module leaf_top
    import leaf_pkg::*;
(
    input  logic         clk,
    input  logic         rst_n,
    input  leaf_packet_t pkt_in,
    output leaf_packet_t pkt_out,
    input  logic         resend,
    output logic [15:0]  drop_count
);

    // ------------------------------------------------------------
    // internal streams
    // ------------------------------------------------------------
    stream_t [`LEAF_NUM_IN_PORTS-1:0]  in_stream;
    logic [`LEAF_NUM_IN_PORTS-1:0]     in_ack;
    stream_t [`LEAF_NUM_OUT_PORTS-1:0] out_stream;
    logic [`LEAF_NUM_OUT_PORTS-1:0]    out_ack;
    route_t [`LEAF_NUM_OUT_PORTS-1:0]  route_table;

    // tree packets in, payloads queued per kernel input.
    leaf_packet_rx packet_rx0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .pkt_in      (pkt_in),
        .in_stream   (in_stream),
        .in_ack      (in_ack),
        .route_table (route_table),
        .drop_count  (drop_count)
    );

    leaf_user_kernel user_kernel0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_stream  (in_stream),
        .in_ack     (in_ack),
        .out_stream (out_stream),
        .out_ack    (out_ack)
    );

    // results packed back into tree packets with the configured routes.
    leaf_packet_tx packet_tx0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .out_stream  (out_stream),
        .out_ack     (out_ack),
        .route_table (route_table),
        .resend      (resend),
        .pkt_out     (pkt_out)
    );

endmodule

`default_nettype wire

// File: leaf_packet_tx.sv
`include "leaf_params.svh"

`default_nettype none

module leaf_packet_tx
    import leaf_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  stream_t [`LEAF_NUM_OUT_PORTS-1:0]   out_stream,
    output logic [`LEAF_NUM_OUT_PORTS-1:0]      out_ack,
    input  route_t [`LEAF_NUM_OUT_PORTS-1:0]    route_table,
    input  logic                                resend,
    output leaf_packet_t                        pkt_out
);

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int OUT_BITS = $clog2(NUM_OUT);

    logic [NUM_OUT-1:0]            hold_vld;
    logic [`LEAF_PAYLOAD_BITS-1:0] hold_data [NUM_OUT];
    logic [NUM_OUT-1:0]            accept;
    logic [OUT_BITS-1:0]           rr_ptr;
    logic [OUT_BITS-1:0]           sel;
    logic [OUT_BITS-1:0]           idx;
    logic                          send;
    data_body_t                    tx_body;
    leaf_packet_t                  pkt_next;
    leaf_packet_t                  pkt_q;

    // ------------------------------------------------------------
    // holding registers
    // ------------------------------------------------------------
    assign out_ack = ~hold_vld;   // a port is acked only while its holding register is empty.

    always_comb begin
        for (int i = 0; i < NUM_OUT; i++) begin
            accept[i] = out_stream[i].vld && out_ack[i];
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hold_vld <= '0;
        end else begin
            for (int i = 0; i < NUM_OUT; i++) begin
                if (accept[i]) begin
                    hold_vld[i] <= 1'b1;
                end else if (send && (sel == OUT_BITS'(i))) begin
                    hold_vld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_OUT; i++) begin
            if (accept[i]) begin
                hold_data[i] <= out_stream[i].data;
            end
        end
    end

    // ------------------------------------------------------------
    // round-robin pick and packet build
    // ------------------------------------------------------------
    // the search runs backwards so the port nearest rr_ptr wins.
    always_comb begin
        sel = rr_ptr;
        idx = rr_ptr;
        for (int k = NUM_OUT - 1; k >= 0; k--) begin
            idx = rr_ptr + OUT_BITS'(k);
            if (hold_vld[idx]) begin
                sel = idx;
            end
        end
    end

    assign send = !resend && |hold_vld;

    always_comb begin
        tx_body.dst_leaf = route_table[sel].dst_leaf;
        tx_body.dst_port = route_table[sel].dst_port;
        tx_body.spare = '0;
        tx_body.payload = hold_data[sel];
        pkt_next = '0;
        if (send) begin
            pkt_next.vld = 1'b1;
            pkt_next.body.data = tx_body;
        end
    end

    // ------------------------------------------------------------
    // output register
    // ------------------------------------------------------------
    // while resend is high the registered word is held until it can be shown.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_q <= '0;
            rr_ptr <= '0;
        end else if (!resend) begin
            pkt_q <= pkt_next;
            if (send) rr_ptr <= sel + 1'b1;   // move past the port just sent.
        end
    end

    assign pkt_out = resend ? '0 : pkt_q;

endmodule

`default_nettype wire

// File: leaf_user_kernel.sv
`include "leaf_params.svh"

`default_nettype none

module leaf_user_kernel
    import leaf_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  stream_t [`LEAF_NUM_IN_PORTS-1:0]    in_stream,
    output logic [`LEAF_NUM_IN_PORTS-1:0]       in_ack,
    output stream_t [`LEAF_NUM_OUT_PORTS-1:0]   out_stream,
    input  logic [`LEAF_NUM_OUT_PORTS-1:0]      out_ack
);

    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;

    logic                          fire_a;
    logic                          fire_b;
    logic [NUM_OUT-1:0]            load;
    logic [NUM_OUT-1:0]            out_vld;
    logic [`LEAF_PAYLOAD_BITS-1:0] out_data [NUM_OUT];
    logic [`LEAF_PAYLOAD_BITS-1:0] result [NUM_OUT];
    logic [`LEAF_PAYLOAD_BITS-1:0] run_sum;

    // ------------------------------------------------------------
    // handshake
    // ------------------------------------------------------------
    // in 1 and in 2 are consumed as a pair, and only into empty outputs.
    assign fire_a = in_stream[0].vld && in_stream[1].vld && !out_vld[0] && !out_vld[1];
    assign fire_b = in_stream[2].vld && !out_vld[2] && !out_vld[3];

    assign in_ack = {fire_b, fire_a, fire_a};
    assign load = {fire_b, fire_b, fire_a, fire_a};

    // ------------------------------------------------------------
    // arithmetic
    // ------------------------------------------------------------
    assign result[0] = in_stream[0].data + in_stream[1].data;
    assign result[1] = in_stream[0].data - in_stream[1].data;
    assign result[2] = in_stream[2].data;
    assign result[3] = run_sum + in_stream[2].data;   // includes the word taken now.

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run_sum <= '0;
        end else if (fire_b) begin
            run_sum <= result[3];
        end
    end

    // ------------------------------------------------------------
    // output registers
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_vld <= '0;
        end else begin
            for (int i = 0; i < NUM_OUT; i++) begin
                if (load[i]) begin
                    out_vld[i] <= 1'b1;
                end else if (out_ack[i]) begin
                    out_vld[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_OUT; i++) begin
            if (load[i]) begin
                out_data[i] <= result[i];
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_OUT; i++) begin
            out_stream[i] = '{vld: out_vld[i], data: out_data[i]};
        end
    end

endmodule

`default_nettype wire

// File: leaf_packet_rx.sv
`include "leaf_params.svh"

`default_nettype none

module leaf_packet_rx
    import leaf_pkg::*;
(
    input  logic                                clk,
    input  logic                                rst_n,
    input  leaf_packet_t                        pkt_in,
    output stream_t [`LEAF_NUM_IN_PORTS-1:0]    in_stream,
    input  logic [`LEAF_NUM_IN_PORTS-1:0]       in_ack,
    output route_t [`LEAF_NUM_OUT_PORTS-1:0]    route_table,
    output logic [15:0]                         drop_count
);

    localparam int NUM_IN = `LEAF_NUM_IN_PORTS;
    localparam int NUM_OUT = `LEAF_NUM_OUT_PORTS;
    localparam int DEPTH = `LEAF_QUEUE_DEPTH;
    localparam int PTR_BITS = $clog2(DEPTH);
    localparam int OUT_BITS = $clog2(NUM_OUT);

    logic                pkt_vld_q;
    packet_body_u        pkt_body_q;
    data_body_t          data_body;
    config_body_t        cfg_body;
    logic                is_data;
    logic                is_cfg;
    logic                cfg_wr;
    logic                bad_port;
    logic                drop;
    logic [OUT_BITS-1:0] cfg_idx;
    logic [NUM_IN-1:0]   push_req;
    logic [NUM_IN-1:0]   push;
    logic [NUM_IN-1:0]   pop;
    logic [NUM_IN-1:0]   full;

    function automatic logic [PTR_BITS-1:0] next_ptr(input logic [PTR_BITS-1:0] ptr);
        return (ptr == PTR_BITS'(DEPTH - 1)) ? '0 : ptr + 1'b1;
    endfunction

    // ------------------------------------------------------------
    // input register and decode
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pkt_vld_q <= 1'b0;
        end else begin
            pkt_vld_q <= pkt_in.vld;
        end
    end

    always_ff @(posedge clk) begin
        pkt_body_q <= pkt_in.body;
    end

    assign data_body = pkt_body_q.data;   // same bits, read two ways.
    assign cfg_body = pkt_body_q.cfg;
    assign is_cfg = pkt_vld_q && (data_body.dst_port == '0);
    assign is_data = pkt_vld_q && (data_body.dst_port != '0);
    assign bad_port = is_data && (data_body.dst_port > PORT_BITS'(NUM_IN));

    always_comb begin
        for (int i = 0; i < NUM_IN; i++) begin
            push_req[i] = is_data && (data_body.dst_port == PORT_BITS'(i + 1));
        end
    end

    // a full queue refuses the word even if it pops in the same cycle.
    assign push = push_req & ~full;
    assign drop = bad_port || |(push_req & full);

    // ------------------------------------------------------------
    // config table and drop counter
    // ------------------------------------------------------------
    // entries outside 1 to 4 are ignored.
    assign cfg_wr = is_cfg && (cfg_body.cfg_out_port != '0) &&
                    (cfg_body.cfg_out_port <= PORT_BITS'(NUM_OUT));
    assign cfg_idx = OUT_BITS'(cfg_body.cfg_out_port - 1'b1);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            route_table <= '0;
        end else if (cfg_wr) begin
            route_table[cfg_idx] <= '{dst_leaf: cfg_body.cfg_dst_leaf,
                                      dst_port: cfg_body.cfg_dst_port};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            drop_count <= '0;
        end else if (drop && (drop_count != 16'hffff)) begin
            drop_count <= drop_count + 16'd1;   // saturates at the top.
        end
    end

    // ------------------------------------------------------------
    // per-port queues with show-ahead read
    // ------------------------------------------------------------
    for (genvar i = 0; i < NUM_IN; i++) begin : g_queue
        logic [`LEAF_PAYLOAD_BITS-1:0] mem [DEPTH];
        logic [PTR_BITS-1:0]           wr_ptr;
        logic [PTR_BITS-1:0]           rd_ptr;
        logic [PTR_BITS:0]             count;

        assign full[i] = (count == (PTR_BITS + 1)'(DEPTH));
        assign pop[i] = in_stream[i].vld && in_ack[i];
        assign in_stream[i] = '{vld: (count != '0), data: mem[rd_ptr]};

        always_ff @(posedge clk) begin
            if (push[i]) begin
                mem[wr_ptr] <= data_body.payload;
            end
        end

        always_ff @(posedge clk) begin
            if (!rst_n) begin
                wr_ptr <= '0;
                rd_ptr <= '0;
                count <= '0;
            end else begin
                if (push[i]) wr_ptr <= next_ptr(wr_ptr);
                if (pop[i]) rd_ptr <= next_ptr(rd_ptr);
                if (push[i] && !pop[i]) begin
                    count <= count + 1'b1;
                end else if (pop[i] && !push[i]) begin
                    count <= count - 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: leaf_pkg.sv
`include "leaf_params.svh"

`default_nettype none

package leaf_pkg;

    localparam int LEAF_BITS = 5;
    localparam int PORT_BITS = 4;
    localparam int BODY_BITS = `LEAF_PACKET_BITS - 1;
    localparam int DATA_SPARE_BITS = BODY_BITS - LEAF_BITS - PORT_BITS - `LEAF_PAYLOAD_BITS;
    localparam int CFG_FIELD_BITS = PORT_BITS + LEAF_BITS + PORT_BITS + 3;
    localparam int CFG_SPARE_BITS = BODY_BITS - LEAF_BITS - PORT_BITS - CFG_FIELD_BITS;

    // ------------------------------------------------------------
    // packet bodies
    // ------------------------------------------------------------
    typedef struct packed {
        logic [LEAF_BITS-1:0]          dst_leaf;
        logic [PORT_BITS-1:0]          dst_port;   // 1 to 3 selects a kernel input.
        logic [DATA_SPARE_BITS-1:0]    spare;
        logic [`LEAF_PAYLOAD_BITS-1:0] payload;
    } data_body_t;

    // the spare field fills the config body out to the full 48 bits.
    typedef struct packed {
        logic [LEAF_BITS-1:0]      dst_leaf;
        logic [PORT_BITS-1:0]      dst_port;       // zero marks a config packet.
        logic [CFG_SPARE_BITS-1:0] spare;
        logic [PORT_BITS-1:0]      cfg_out_port;
        logic [LEAF_BITS-1:0]      cfg_dst_leaf;
        logic [PORT_BITS-1:0]      cfg_dst_port;
        logic [2:0]                pad;
    } config_body_t;

    typedef union packed {
        data_body_t   data;
        config_body_t cfg;
    } packet_body_u;

    typedef struct packed {
        logic         vld;
        packet_body_u body;
    } leaf_packet_t;

    // ------------------------------------------------------------
    // routing and kernel streams
    // ------------------------------------------------------------
    typedef struct packed {
        logic [LEAF_BITS-1:0] dst_leaf;
        logic [PORT_BITS-1:0] dst_port;
    } route_t;

    typedef struct packed {
        logic                          vld;
        logic [`LEAF_PAYLOAD_BITS-1:0] data;
    } stream_t;

endpackage

`default_nettype wire

// File: leaf_params.svh
`ifndef LEAF_PARAMS_SVH
`define LEAF_PARAMS_SVH

`default_nettype none

// ------------------------------------------------------------
// packet geometry
// ------------------------------------------------------------
`define LEAF_PACKET_BITS 49   // one valid bit over a 48-bit body.
`define LEAF_PAYLOAD_BITS 32

// ------------------------------------------------------------
// kernel ports and buffering
// ------------------------------------------------------------
`define LEAF_NUM_IN_PORTS 3
`define LEAF_NUM_OUT_PORTS 4

// entries in each input queue.
`define LEAF_QUEUE_DEPTH 8

`default_nettype wire

`endif
